//--- fpAddSubCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module fpAddSubCtrl (
	input wire clk,
	input wire rst,
	input wire start,
	input wire normDone,			// Leading one in place or zero
	input wire cntZero,			// Step budget spent
	input wire excAny,			// Special input, skip the datapath
	output logic busy,
	output logic done,
	output logic alignLoad,			// Operand capture, accepted start only
	output logic addLoad,
	output logic normLoad,
	output logic normStep,
	output logic roundLoad,
	output logic cntLoad,
	output logic cntDec
);

	fpCtrlPkg::ctrlState state;
	fpCtrlPkg::ctrlState stateNext;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fpCtrlPkg::IDLE;
		end else begin
			state <= stateNext;
		end
	end

	always_comb begin
		stateNext = state;
		alignLoad = 1'b0;
		addLoad = 1'b0;
		normLoad = 1'b0;
		normStep = 1'b0;
		roundLoad = 1'b0;
		cntLoad = 1'b0;
		cntDec = 1'b0;
		case (state)
			fpCtrlPkg::IDLE: begin
				alignLoad = start;		// Start outside IDLE is dropped
				if (start) begin
					stateNext = fpCtrlPkg::ALIGN;
				end
			end
			fpCtrlPkg::ALIGN: begin
				addLoad = 1'b1;			// Sign also feeds special results
				stateNext = excAny ? fpCtrlPkg::ROUND : fpCtrlPkg::ADD;
			end
			fpCtrlPkg::ADD: begin
				normLoad = 1'b1;
				cntLoad = 1'b1;			// Arm the step bound
				stateNext = fpCtrlPkg::NORM;
			end
			fpCtrlPkg::NORM: begin
				if (normDone || cntZero) begin
					stateNext = fpCtrlPkg::ROUND;
				end else begin
					normStep = 1'b1;
					cntDec = 1'b1;
				end
			end
			fpCtrlPkg::ROUND: begin
				roundLoad = 1'b1;
				stateNext = fpCtrlPkg::DONE;
			end
			fpCtrlPkg::DONE: begin
				stateNext = fpCtrlPkg::IDLE;	// Single-cycle done
			end
			default: begin
				stateNext = fpCtrlPkg::IDLE;
			end
		endcase
	end

	assign busy = (state != fpCtrlPkg::IDLE);	// Drops with done
	assign done = (state == fpCtrlPkg::DONE);

endmodule

`default_nettype wire

//--- fpAddSubPatterns.txt
# Columns, all hex: operand a, operand b, op (0 add, 1 subtract), expected result, expected exc
# exc bits: 4 any, 3 a NaN, 2 b NaN, 1 a inf, 0 b inf
3C00 3C00 0 4000 00
3C00 3800 0 3E00 00
3C00 0400 0 3C00 00
7800 3C00 0 7800 00
3C00 3BFE 1 1400 00
4248 4248 1 0000 00
C248 C248 1 0000 00
4000 BC00 0 3C00 00
3C00 1000 0 3C00 00
3C01 1000 0 3C02 00
3C00 1001 0 3C01 00
3FFF 1000 0 4000 00
7BFF 7BFF 0 7C00 00
FBFF FBFF 0 FC00 00
0600 0400 1 0000 00
8600 8400 1 8000 00
7E00 3C00 0 7E00 18
3C00 7C01 0 7E00 14
7C00 3C00 0 7C00 12
3C00 7C00 1 FC00 11
7C00 7C00 1 7E00 13
FC00 FC00 0 FC00 13

//--- fpAddSubTb.sv
`timescale 1ns/1ps
`default_nettype none

module fpAddSubTb;

	localparam logic [31:0] Seed = 32'h8f3e566d;
	localparam int DoneTimeout = 40;			// Cycles from start to done, worst case is 17
	localparam string PatternFile = "fpAddSubPatterns.txt";

	logic clk;
	logic rst;
	logic start;
	logic [15:0] a;
	logic [15:0] b;
	logic op;
	wire busy;
	wire done;
	wire [15:0] result;
	wire [4:0] exc;
	wire overflow;

	int patternCount;

	fpAddSubTop i_dut (
		.clk(clk),
		.rst(rst),
		.start(start),
		.a(a),
		.b(b),
		.op(op),
		.busy(busy),
		.done(done),
		.result(result),
		.exc(exc),
		.overflow(overflow)
	);

	always #20 clk = ~clk;					// 40 ns period

	task automatic checkValue(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		if (got !== expected) begin
			$display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, expected);
			$display(">>> FAIL");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic abortRun(input string why);
		$display("ERROR time=%0t %s", $time, why);
		$display(">>> FAIL");
		$fatal(1, "Run aborted");
	endtask

	// Inputs change just after the edge, outputs are settled there too
	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic runOp(input logic [15:0] opA, input logic [15:0] opB, input logic opSel,
		input logic [15:0] expResult, input logic [4:0] expExc);
		int cycles;
		int gap;
		logic expOvf;
		// Finite inputs that end at infinity overflowed
		expOvf = (expResult[14:0] == 15'h7C00) && (expExc == 5'd0);
		a = opA;
		b = opB;
		op = opSel;
		start = 1'b1;
		nextCycle();
		start = 1'b0;
		checkValue("busy", busy, 1'b1);			// Rises the cycle after start
		cycles = 0;
		while (!done) begin
			if (cycles >= DoneTimeout) begin
				abortRun("done did not arrive within the timeout");
			end
			if (busy && ($urandom_range(3) == 0)) begin	// Stray start, must be ignored
				start = 1'b1;
				a = 16'($urandom);
				b = 16'($urandom);
				op = 1'($urandom);
			end
			nextCycle();
			start = 1'b0;
			cycles++;
		end
		checkValue("result", result, expResult);
		checkValue("exc", 16'(exc), 16'(expExc));
		checkValue("overflow", overflow, expOvf);
		nextCycle();
		checkValue("done", done, 1'b0);			// Single-cycle strobe
		checkValue("busy", busy, 1'b0);
		gap = $urandom_range(3);
		repeat (gap) begin
			nextCycle();
			checkValue("result", result, expResult);	// Held while idle
		end
	endtask

	initial begin
		int fd;
		int code;
		string line;
		logic [15:0] pa;
		logic [15:0] pb;
		logic po;
		logic [15:0] pr;
		logic [4:0] pe;
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		a = '0;
		b = '0;
		op = 1'b0;
		patternCount = 0;
		void'($urandom(Seed));
		repeat (3) @(posedge clk);				// Three reset edges
		#1;
		rst = 1'b0;
		checkValue("busy", busy, 1'b0);
		checkValue("done", done, 1'b0);
		checkValue("overflow", overflow, 1'b0);
		checkValue("result", result, 16'h0000);
		fd = $fopen(PatternFile, "r");
		if (fd == 0) begin
			abortRun("cannot open the pattern file");
		end
		while ($fgets(line, fd) != 0) begin
			if ((line.len() > 1) && (line.getc(0) != "#")) begin	// Skip notes and blanks
				code = $sscanf(line, "%h %h %h %h %h", pa, pb, po, pr, pe);
				if (code != 5) begin
					abortRun("pattern line does not hold five fields");
				end
				runOp(pa, pb, po, pr, pe);
				patternCount++;
			end
		end
		$fclose(fd);
		if (patternCount == 0) begin
			abortRun("pattern file held no operations");
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- fpAddSubTop.sv
`timescale 1ns/1ps
`default_nettype none

module fpAddSubTop #(
	parameter int ExpWidth = fpFormatPkg::ExpWidth,
	parameter int ManWidth = fpFormatPkg::ManWidth
) (
	input wire clk,
	input wire rst,
	input wire start,
	input wire [ExpWidth+ManWidth:0] a,
	input wire [ExpWidth+ManWidth:0] b,
	input wire op,					// 0 adds, 1 subtracts
	output wire busy,
	output wire done,
	output wire [ExpWidth+ManWidth:0] result,
	output wire [4:0] exc,
	output wire overflow
);

	localparam int NormSteps = ManWidth + fpFormatPkg::ExtraBits;	// Worst-case shifts
	localparam int CntWidth = $clog2(NormSteps + 1);
	localparam int SigWidth = ManWidth + 1 + fpFormatPkg::ExtraBits;

	wire alignLoad;
	wire addLoad;
	wire normLoad;
	wire normStep;
	wire roundLoad;
	wire cntLoad;
	wire cntDec;
	wire cntZero;
	wire normDone;
	wire sBig;
	wire opEff;
	wire sumSign;
	wire [ExpWidth-1:0] expBig;
	wire [SigWidth-1:0] manBig;
	wire [SigWidth-1:0] manSmall;
	wire [SigWidth:0] sum;
	wire [4:0] inputExc;

	fpAlignShift #(
		.ExpWidth(ExpWidth),
		.ManWidth(ManWidth)
	) i_alignShift (
		.clk(clk),
		.rst(rst),
		.load(alignLoad),
		.a(a),
		.b(b),
		.op(op),
		.sa(sBig),
		.sb(),					// Smaller sign is folded into opEff
		.opEff(opEff),
		.expBig(expBig),
		.manBig(manBig),
		.manSmall(manSmall),
		.inputExc(inputExc)
	);

	fpMantAdd #(
		.ManWidth(ManWidth)
	) i_mantAdd (
		.clk(clk),
		.rst(rst),
		.load(addLoad),
		.opEff(opEff),
		.sBig(sBig),
		.manBig(manBig),
		.manSmall(manSmall),
		.sum(sum),
		.sumSign(sumSign)
	);

	fpNormalize #(
		.ExpWidth(ExpWidth),
		.ManWidth(ManWidth)
	) i_normalize (
		.clk(clk),
		.rst(rst),
		.load(normLoad),
		.step(normStep),
		.roundLoad(roundLoad),
		.sum(sum),
		.sign(sumSign),
		.expBig(expBig),
		.inputExc(inputExc),
		.normDone(normDone),
		.result(result),
		.exc(exc),
		.overflow(overflow)
	);

	fpCycleCounter #(
		.Width(CntWidth)
	) i_cycleCounter (
		.clk(clk),
		.rst(rst),
		.load(cntLoad),
		.dec(cntDec),
		.loadValue(CntWidth'(NormSteps)),
		.zero(cntZero)
	);

	fpAddSubCtrl i_ctrl (
		.clk(clk),
		.rst(rst),
		.start(start),
		.normDone(normDone),
		.cntZero(cntZero),
		.excAny(inputExc[fpCtrlPkg::ExcAny]),
		.busy(busy),
		.done(done),
		.alignLoad(alignLoad),
		.addLoad(addLoad),
		.normLoad(normLoad),
		.normStep(normStep),
		.roundLoad(roundLoad),
		.cntLoad(cntLoad),
		.cntDec(cntDec)
	);

endmodule

`default_nettype wire

//--- fpAddSub_assert.sv
`timescale 1ns/1ps
`default_nettype none

module fpAddSubAssert (
	input wire clk,
	input wire rst,
	input wire busy,
	input wire done,
	input wire addLoad,
	input wire normLoad,
	input wire normStep,
	input wire roundLoad,
	input wire cntLoad,
	input wire cntDec
);

	doneOneCycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("done lasted more than one cycle");

	// Both drop at the same edge
	busyDropsWithDone: assert property (@(posedge clk) disable iff (rst) done |=> !busy)
		else $error("busy stayed high after done");

	busyFallSource: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> $past(done))
		else $error("busy fell without done");

	// Capture strobe is the only IDLE enable
	idleNoLoads: assert property (@(posedge clk) disable iff (rst)
		!busy |-> !(addLoad || normLoad || normStep || roundLoad || cntLoad || cntDec))
		else $error("stage enable fired in IDLE");

endmodule

bind fpAddSubCtrl fpAddSubAssert i_assert (
	.clk(clk),
	.rst(rst),
	.busy(busy),
	.done(done),
	.addLoad(addLoad),
	.normLoad(normLoad),
	.normStep(normStep),
	.roundLoad(roundLoad),
	.cntLoad(cntLoad),
	.cntDec(cntDec)
);

`default_nettype wire

//--- fpAlignShift.sv
`timescale 1ns/1ps
`default_nettype none

module fpAlignShift #(
	parameter int ExpWidth = fpFormatPkg::ExpWidth,
	parameter int ManWidth = fpFormatPkg::ManWidth
) (
	input wire clk,
	input wire rst,
	input wire load,						// Capture operands
	input wire [ExpWidth+ManWidth:0] a,
	input wire [ExpWidth+ManWidth:0] b,
	input wire op,
	output logic sa,						// Larger magnitude sign, op applied
	output logic sb,						// Smaller magnitude sign, op applied
	output logic opEff,						// 1 when magnitudes subtract
	output logic [ExpWidth-1:0] expBig,
	output logic [ManWidth+fpFormatPkg::ExtraBits:0] manBig,	// Hidden one, mantissa, GRS
	output logic [ManWidth+fpFormatPkg::ExtraBits:0] manSmall,	// Aligned, sticky in LSB
	output logic [4:0] inputExc
);

	localparam int Extra = fpFormatPkg::ExtraBits;
	localparam int SigWidth = ManWidth + 1 + Extra;

	logic [ExpWidth+ManWidth:0] aReg;
	logic [ExpWidth+ManWidth:0] bReg;
	logic opReg;
	logic rawSa;
	logic rawSb;
	logic opPre;
	logic sbEff;
	logic [2*ExpWidth-1:0] shiftDet;
	logic [ExpWidth+ManWidth-1:0] aMag;
	logic [ExpWidth+ManWidth-1:0] bMag;
	logic [ExpWidth-1:0] expA;
	logic [ExpWidth-1:0] expB;
	logic [ManWidth-1:0] fracA;
	logic [ManWidth-1:0] fracB;
	logic [ExpWidth:0] expCmp;
	logic aSmaller;
	logic [ExpWidth-1:0] shiftAmt;
	logic [SigWidth-1:0] sigA;
	logic [SigWidth-1:0] sigB;
	logic [SigWidth-1:0] sigSmall;
	logic [SigWidth-1:0] shifted;
	logic [SigWidth-1:0] lostMask;

	always_ff @(posedge clk) begin
		if (rst) begin
			aReg <= '0;
			bReg <= '0;
			opReg <= 1'b0;
		end else if (load) begin
			aReg <= a;				// Held until next accepted start
			bReg <= b;
			opReg <= op;
		end
	end

	fpPrealign #(
		.ExpWidth(ExpWidth),
		.ManWidth(ManWidth)
	) i_prealign (
		.a(aReg),
		.b(bReg),
		.op(opReg),
		.sa(rawSa),
		.sb(rawSb),
		.shiftDet(shiftDet),
		.inputExc(inputExc),
		.aOut(aMag),
		.bOut(bMag),
		.opOut(opPre)
	);

	assign expA = aMag[ExpWidth+ManWidth-1:ManWidth];
	assign expB = bMag[ExpWidth+ManWidth-1:ManWidth];
	assign fracA = aMag[ManWidth-1:0];
	assign fracB = bMag[ManWidth-1:0];

	// Zero exponent counts as zero, no hidden one and no fraction
	assign sigA = (expA != '0) ? {1'b1, fracA, {Extra{1'b0}}} : '0;
	assign sigB = (expB != '0) ? {1'b1, fracB, {Extra{1'b0}}} : '0;

	// Borrow of widened difference is the exponent compare
	assign expCmp = {1'b0, expA} - {1'b0, expB};
	assign aSmaller = expCmp[ExpWidth] | ((expA == expB) & (fracA < fracB));

	assign sbEff = rawSb ^ opPre;				// Subtract flips B
	assign opEff = rawSa ^ sbEff;
	assign sa = aSmaller ? sbEff : rawSa;
	assign sb = aSmaller ? rawSa : sbEff;
	assign expBig = aSmaller ? expB : expA;
	assign manBig = aSmaller ? sigB : sigA;
	assign sigSmall = aSmaller ? sigA : sigB;

	// Positive half of shiftDet for the chosen order
	assign shiftAmt = aSmaller ? shiftDet[2*ExpWidth-1:ExpWidth] : shiftDet[ExpWidth-1:0];
	assign shifted = sigSmall >> shiftAmt;
	assign lostMask = ~({SigWidth{1'b1}} << shiftAmt);	// Bits pushed out the bottom
	assign manSmall = {shifted[SigWidth-1:1], shifted[0] | (|(sigSmall & lostMask))};

endmodule

`default_nettype wire

//--- fpCtrlPkg.sv
`default_nettype none

package fpCtrlPkg;

	// Controller sequence, one operation in flight
	typedef enum logic [2:0] {
		IDLE,		// Waiting for start
		ALIGN,		// Operands held, swap and shift settle
		ADD,		// Magnitude sum registered
		NORM,		// Left shifts until leading one
		ROUND,		// Round, pack, special substitution
		DONE		// Result valid, done strobe
	} ctrlState;

	// Bit positions in the 5-bit exception vector
	localparam int ExcAny = 4;	// Any of the four below
	localparam int ExcANaN = 3;	// A is NaN
	localparam int ExcBNaN = 2;	// B is NaN
	localparam int ExcAInf = 1;	// A is infinity
	localparam int ExcBInf = 0;	// B is infinity

endpackage

`default_nettype wire

//--- fpCycleCounter.sv
`timescale 1ns/1ps
`default_nettype none

module fpCycleCounter #(
	parameter int Width = 4
) (
	input wire clk,
	input wire rst,
	input wire load,				// Load wins over dec
	input wire dec,
	input wire [Width-1:0] loadValue,
	output logic zero
);

	logic [Width-1:0] count;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (load) begin
			count <= loadValue;
		end else if (dec && (count != '0)) begin
			count <= count - 1'b1;		// Saturates at zero
		end
	end

	assign zero = (count == '0);

endmodule

`default_nettype wire

//--- fpFormatPkg.sv
`default_nettype none

package fpFormatPkg;

	// Binary16 field layout
	localparam int ExpWidth = 5;			// Exponent field
	localparam int ManWidth = 10;			// Stored mantissa, hidden one not counted
	localparam int Bias = 15;			// Exponent bias

	// Extra precision kept below the mantissa LSB during align and normalize
	localparam int ExtraBits = 3;			// Guard, round, sticky

	// Special encodings
	localparam logic [15:0] QuietNaN = 16'h7E00;	// Canonical quiet NaN, sign clear
	localparam logic [14:0] InfMag = 15'h7C00;	// All-ones exponent, zero mantissa

endpackage

`default_nettype wire

//--- fpMantAdd.sv
`timescale 1ns/1ps
`default_nettype none

module fpMantAdd #(
	parameter int ManWidth = fpFormatPkg::ManWidth
) (
	input wire clk,
	input wire rst,
	input wire load,						// Register the sum
	input wire opEff,						// 1 subtracts magnitudes
	input wire sBig,						// Larger operand sign
	input wire [ManWidth+fpFormatPkg::ExtraBits:0] manBig,
	input wire [ManWidth+fpFormatPkg::ExtraBits:0] manSmall,
	output logic [ManWidth+fpFormatPkg::ExtraBits+1:0] sum,		// Carry bit on top
	output logic sumSign
);

	localparam int SumWidth = ManWidth + fpFormatPkg::ExtraBits + 2;

	logic [SumWidth-1:0] bigExt;
	logic [SumWidth-1:0] smallExt;
	logic [SumWidth-1:0] sumNext;
	logic exactZero;

	assign bigExt = {1'b0, manBig};
	assign smallExt = {1'b0, manSmall};

	// Larger magnitude first, so subtraction never goes negative
	assign sumNext = opEff ? (bigExt - smallExt) : (bigExt + smallExt);
	assign exactZero = opEff & (manBig == manSmall);	// x - x

	always_ff @(posedge clk) begin
		if (rst) begin
			sum <= '0;
			sumSign <= 1'b0;
		end else if (load) begin
			sum <= sumNext;
			sumSign <= exactZero ? 1'b0 : sBig;		// Cancellation gives +0
		end
	end

endmodule

`default_nettype wire

//--- fpNormalize.sv
`timescale 1ns/1ps
`default_nettype none

module fpNormalize #(
	parameter int ExpWidth = fpFormatPkg::ExpWidth,
	parameter int ManWidth = fpFormatPkg::ManWidth
) (
	input wire clk,
	input wire rst,
	input wire load,						// Take the sum
	input wire step,						// One left shift
	input wire roundLoad,						// Round and pack
	input wire [ManWidth+fpFormatPkg::ExtraBits+1:0] sum,
	input wire sign,
	input wire [ExpWidth-1:0] expBig,
	input wire [4:0] inputExc,
	output logic normDone,
	output logic [ExpWidth+ManWidth:0] result,
	output logic [4:0] exc,
	output logic overflow
);

	localparam int Extra = fpFormatPkg::ExtraBits;
	localparam int SigWidth = ManWidth + 1 + Extra;
	localparam int SumWidth = SigWidth + 1;

	logic [SigWidth-1:0] manReg;
	logic [ExpWidth:0] expReg;				// One spare bit for overflow
	logic signReg;
	logic uflow;						// Fell below smallest normal
	logic guardBit;
	logic stickyBit;
	logic roundUp;
	logic [ManWidth+1:0] rounded;				// Hidden one plus carry
	logic [ExpWidth:0] expRound;
	logic nanOut;
	logic infOut;
	logic ovfNext;
	logic [ExpWidth+ManWidth:0] resultNext;

	assign normDone = manReg[SigWidth-1] | (manReg == '0) | uflow;

	always_ff @(posedge clk) begin
		if (rst) begin
			manReg <= '0;
			expReg <= '0;
			signReg <= 1'b0;
			uflow <= 1'b0;
		end else if (load) begin
			signReg <= sign;
			uflow <= 1'b0;
			if (sum[SumWidth-1]) begin		// Carry out, shift right once
				manReg <= {sum[SumWidth-1:2], sum[1] | sum[0]};
				expReg <= {1'b0, expBig} + 1'b1;
			end else begin
				manReg <= sum[SigWidth-1:0];
				expReg <= {1'b0, expBig};
			end
		end else if (step && !normDone) begin
			if (expReg <= 1) begin
				uflow <= 1'b1;			// Next exponent would be 0
			end else begin
				manReg <= manReg << 1;
				expReg <= expReg - 1'b1;
			end
		end
	end

	// Nearest even, ties go to even LSB
	assign guardBit = manReg[Extra-1];
	assign stickyBit = |manReg[Extra-2:0];
	assign roundUp = guardBit & (stickyBit | manReg[Extra]);
	assign rounded = {1'b0, manReg[SigWidth-1:Extra]} + roundUp;
	assign expRound = expReg + rounded[ManWidth+1];		// 1.111.. rounds to 10.000..

	// Opposite infinities cancel to an exact zero sum
	assign nanOut = inputExc[fpCtrlPkg::ExcANaN] | inputExc[fpCtrlPkg::ExcBNaN] |
		(inputExc[fpCtrlPkg::ExcAInf] & inputExc[fpCtrlPkg::ExcBInf] & (sum == '0));
	assign infOut = inputExc[fpCtrlPkg::ExcAInf] | inputExc[fpCtrlPkg::ExcBInf];

	always_comb begin
		ovfNext = 1'b0;
		if (nanOut) begin
			resultNext = fpFormatPkg::QuietNaN;
		end else if (infOut) begin
			resultNext = {sign, fpFormatPkg::InfMag};	// Sign of the infinite operand
		end else if (uflow || (manReg == '0)) begin
			resultNext = {signReg, {(ExpWidth+ManWidth){1'b0}}};
		end else if (expRound > 2 * fpFormatPkg::Bias) begin
			resultNext = {signReg, fpFormatPkg::InfMag};
			ovfNext = 1'b1;
		end else begin
			resultNext = {signReg, expRound[ExpWidth-1:0], rounded[ManWidth-1:0]};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			result <= '0;
			exc <= '0;
			overflow <= 1'b0;
		end else if (roundLoad) begin
			result <= resultNext;			// Held until next roundLoad
			exc <= inputExc;
			overflow <= ovfNext;
		end
	end

endmodule

`default_nettype wire

//--- fpPrealign.sv
`timescale 1ns/1ps
`default_nettype none

module fpPrealign #(
	parameter int ExpWidth = fpFormatPkg::ExpWidth,
	parameter int ManWidth = fpFormatPkg::ManWidth
) (
	input wire [ExpWidth+ManWidth:0] a,		// Operand A, sign/exp/mantissa
	input wire [ExpWidth+ManWidth:0] b,		// Operand B
	input wire op,					// 1 subtracts
	output logic sa,				// A sign
	output logic sb,				// B sign, op not applied
	output logic [2*ExpWidth-1:0] shiftDet,		// {ExpB-ExpA, ExpA-ExpB}
	output logic [4:0] inputExc,			// Input exception vector
	output logic [ExpWidth+ManWidth-1:0] aOut,	// A magnitude
	output logic [ExpWidth+ManWidth-1:0] bOut,	// B magnitude
	output logic opOut
);

	logic [ExpWidth-1:0] expA;
	logic [ExpWidth-1:0] expB;
	logic aNaN;
	logic bNaN;
	logic aInf;
	logic bInf;
	logic [ExpWidth-1:0] dab;			// ExpA - ExpB, modulo 2^ExpWidth
	logic [ExpWidth-1:0] dba;			// ExpB - ExpA

	assign expA = a[ExpWidth+ManWidth-1:ManWidth];
	assign expB = b[ExpWidth+ManWidth-1:ManWidth];

	// All-ones exponent marks a special value
	assign aNaN = (&expA) & (|a[ManWidth-1:0]);	// Nonzero mantissa
	assign bNaN = (&expB) & (|b[ManWidth-1:0]);
	assign aInf = (&expA) & ~(|a[ManWidth-1:0]);	// Zero mantissa
	assign bInf = (&expB) & ~(|b[ManWidth-1:0]);

	always_comb begin
		inputExc = '0;
		inputExc[fpCtrlPkg::ExcAny] = aNaN | bNaN | aInf | bInf;
		inputExc[fpCtrlPkg::ExcANaN] = aNaN;
		inputExc[fpCtrlPkg::ExcBNaN] = bNaN;
		inputExc[fpCtrlPkg::ExcAInf] = aInf;
		inputExc[fpCtrlPkg::ExcBInf] = bInf;
	end

	// Two's-complement differences, both directions
	assign dab = expA + ~expB + 1'b1;
	assign dba = expB + ~expA + 1'b1;

	assign sa = a[ExpWidth+ManWidth];
	assign sb = b[ExpWidth+ManWidth];
	assign shiftDet = {dba, dab};
	assign aOut = a[ExpWidth+ManWidth-1:0];
	assign bOut = b[ExpWidth+ManWidth-1:0];
	assign opOut = op;

endmodule

`default_nettype wire

//--- list.f
fpFormatPkg.sv
fpCtrlPkg.sv
fpPrealign.sv
fpAlignShift.sv
fpMantAdd.sv
fpNormalize.sv
fpCycleCounter.sv
fpAddSubCtrl.sv
fpAddSubTop.sv
fpAddSub_assert.sv
fpAddSubTb.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator, then decide from the simulation log
rm -rf obj_dir build.log sim.log &&
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module fpAddSubTb \
	-o fpAddSubSim > build.log 2>&1 &&
./obj_dir/fpAddSubSim > sim.log 2>&1 ||
echo "build or simulation reported an error, see build.log and sim.log"
grep -q ">>> PASS" sim.log && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
